//--- hdl/baud_gen.sv
`timescale 1ns/1ns

module baud_gen
    (
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic [uart_pkg::DVSR_BITS-1:0]  i_dvsr,     // Period minus one
        output logic                            o_tick      // Oversampling tick
    );

    import uart_pkg::*;

    logic [DVSR_BITS-1:0] cnt_reg;                  // Cycles left to next tick
    logic [DVSR_BITS-1:0] cnt_next;

    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
            cnt_reg <= '0;
        else
            cnt_reg <= cnt_next;
    end

    // Down count, divisor only sampled on wrap
    // so a new value starts with the next period
    always_comb
    begin
        if (cnt_reg == '0)
            cnt_next = i_dvsr;                      // Reload
        else
            cnt_next = cnt_reg - 1'b1;
    end

    // One cycle in every i_dvsr+1
    assign o_tick = (cnt_reg == '0);

endmodule

//--- hdl/fifo.sv
`timescale 1ns/1ns

module fifo
    #(
        parameter int B = 8,                        // Word width
        parameter int W = 4                         // Address bits, 2**W entries
    )
    (
        input  logic          i_clk,
        input  logic          i_reset,
        input  logic          i_rd,                 // Pop head
        input  logic          i_wr,                 // Push word
        input  logic [B-1:0]  i_w_data,
        output logic          o_empty,
        output logic          o_full,
        output logic [B-1:0]  o_r_data              // Head word, no register stage
    );

    logic [B-1:0] array_reg [0:2**W-1];             // Storage, circular queue
    logic [W-1:0] w_ptr_reg, w_ptr_next, w_ptr_succ;
    logic [W-1:0] r_ptr_reg, r_ptr_next, r_ptr_succ;
    logic         full_reg, full_next;
    logic         empty_reg, empty_next;
    logic         wr_ok;                            // Accepted write
    logic         rd_ok;                            // Accepted read

    // Strobes only count when status allows
    assign wr_ok = i_wr & ~full_reg;
    assign rd_ok = i_rd & ~empty_reg;

    // Storage write, no reset on payload
    always_ff @(posedge i_clk)
    begin
        if (wr_ok)
            array_reg[w_ptr_reg] <= i_w_data;
    end

    assign o_r_data = array_reg[r_ptr_reg];         // Head shown combinationally

    // Pointers and status flops
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            w_ptr_reg <= '0;
            r_ptr_reg <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;                      // Starts empty
        end
        else
        begin
            w_ptr_reg <= w_ptr_next;
            r_ptr_reg <= r_ptr_next;
            full_reg  <= full_next;
            empty_reg <= empty_next;
        end
    end

    always_comb
    begin
        w_ptr_succ = w_ptr_reg + 1'b1;              // Wraps at 2**W
        r_ptr_succ = r_ptr_reg + 1'b1;
        w_ptr_next = w_ptr_reg;                     // Hold by default
        r_ptr_next = r_ptr_reg;
        full_next  = full_reg;
        empty_next = empty_reg;

        // Gated pair, so empty FIFO never moves read pointer
        case ({wr_ok, rd_ok})
            2'b01:                                  // Read only
            begin
                r_ptr_next = r_ptr_succ;
                full_next  = 1'b0;
                if (r_ptr_succ == w_ptr_reg)
                    empty_next = 1'b1;              // Last entry gone
            end
            2'b10:                                  // Write only
            begin
                w_ptr_next = w_ptr_succ;
                empty_next = 1'b0;
                if (w_ptr_succ == r_ptr_reg)
                    full_next = 1'b1;               // Caught up with tail
            end
            2'b11:                                  // Both, occupancy unchanged
            begin
                w_ptr_next = w_ptr_succ;
                r_ptr_next = r_ptr_succ;
            end
            default:
            begin
                // Nothing accepted, hold
            end
        endcase
    end

    assign o_full  = full_reg;
    assign o_empty = empty_reg;

endmodule

//--- hdl/uart_pkg.sv
package uart_pkg;

    // Frame format, 8N1
    localparam int DATA_BITS = 8;                   // Data bits per frame
    localparam int SB_TICKS = 16;                   // Oversampling ticks per bit, stop bit too
    localparam int MID_TICK = SB_TICKS / 2 - 1;     // Tick count at start-bit centre
    localparam int TICK_BITS = $clog2(SB_TICKS);    // Tick counter width
    localparam int CNT_BITS = $clog2(DATA_BITS);    // Bit counter width

    // Buffering
    localparam int FIFO_ADDR_BITS = 4;              // 16 entries per FIFO

    // Bit rate
    localparam int DVSR_BITS = 11;                  // Baud divisor width

    // One byte of payload
    typedef logic [DATA_BITS-1:0] data_t;

    // Shared by both serial FSMs
    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } uart_state_t;

endpackage

//--- hdl/uart_rx.sv
`timescale 1ns/1ns

module uart_rx
    (
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_rx,               // Serial line, idles high
        input  logic            i_s_tick,           // 16x oversampling tick
        output logic            o_rx_done_tick,     // One cycle per received byte
        output uart_pkg::data_t o_dout
    );

    import uart_pkg::*;

    uart_state_t          state_reg, state_next;
    logic [TICK_BITS-1:0] s_reg, s_next;            // Ticks within a bit
    logic [CNT_BITS-1:0]  n_reg, n_next;            // Data bits received
    data_t                b_reg, b_next;            // Shift register, LSB first
    logic [1:0]           rx_sync;                  // Line synchronizer
    logic                 rx_s;                     // Synchronized line

    // Two flops on the asynchronous line, idle level out of reset
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
            rx_sync <= 2'b11;
        else
            rx_sync <= {rx_sync[0], i_rx};
    end

    assign rx_s = rx_sync[1];

    // FSM state and counters
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            state_reg <= ST_IDLE;
            s_reg     <= '0;
            n_reg     <= '0;
        end
        else
        begin
            state_reg <= state_next;
            s_reg     <= s_next;
            n_reg     <= n_next;
        end
    end

    // Payload
    always_ff @(posedge i_clk)
    begin
        b_reg <= b_next;
    end

    always_comb
    begin
        state_next     = state_reg;
        s_next         = s_reg;
        n_next         = n_reg;
        b_next         = b_reg;
        o_rx_done_tick = 1'b0;

        case (state_reg)
            ST_IDLE:
            begin
                if (~rx_s)                          // Falling edge, maybe a start bit
                begin
                    state_next = ST_START;
                    s_next     = '0;
                end
            end
            ST_START:
            begin
                if (i_s_tick)
                begin
                    if (s_reg == TICK_BITS'(MID_TICK))
                    begin
                        if (~rx_s)                  // Still low at centre
                        begin
                            state_next = ST_DATA;
                            s_next     = '0;
                            n_next     = '0;
                        end
                        else
                            state_next = ST_IDLE;   // Glitch, drop it
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            ST_DATA:
            begin
                if (i_s_tick)
                begin
                    if (s_reg == TICK_BITS'(SB_TICKS - 1))   // Next bit centre
                    begin
                        s_next = '0;
                        b_next = {rx_s, b_reg[DATA_BITS-1:1]};
                        if (n_reg == CNT_BITS'(DATA_BITS - 1))
                            state_next = ST_STOP;
                        else
                            n_next = n_reg + 1'b1;
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            ST_STOP:
            begin
                if (i_s_tick)
                begin
                    if (s_reg == TICK_BITS'(SB_TICKS - 1))
                    begin
                        state_next     = ST_IDLE;
                        o_rx_done_tick = 1'b1;      // Byte complete
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            default:
                state_next = ST_IDLE;
        endcase
    end

    assign o_dout = b_reg;

endmodule

//--- hdl/uart_top.sv
`timescale 1ns/1ns

module uart_top
    (
        input  logic                            i_clk,
        input  logic                            i_reset,
        // Bit rate
        input  logic [uart_pkg::DVSR_BITS-1:0]  i_dvsr,
        // Serial lines
        input  logic                            i_rx,
        output logic                            o_tx,
        // Host transmit side
        input  logic                            i_wr_uart,
        input  uart_pkg::data_t                 i_w_data,
        output logic                            o_tx_full,
        // Host receive side
        input  logic                            i_rd_uart,
        output uart_pkg::data_t                 o_r_data,
        output logic                            o_rx_empty
    );

    import uart_pkg::*;

    logic  s_tick;                                  // Shared oversampling tick
    logic  rx_done_tick;                            // Receive FIFO write strobe
    data_t rx_dout;                                 // Received byte
    logic  tx_fifo_empty;
    data_t tx_fifo_out;                             // Head of transmit FIFO
    logic  tx_start;
    logic  tx_done_tick;                            // Transmit FIFO read strobe

    // Bit rate
    baud_gen baud_gen_unit
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_dvsr  (i_dvsr),
        .o_tick  (s_tick)
    );

    // Receive path, line to FIFO to host
    uart_rx uart_rx_unit
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rx           (i_rx),
        .i_s_tick       (s_tick),
        .o_rx_done_tick (rx_done_tick),
        .o_dout         (rx_dout)
    );

    fifo
    #(
        .B ($bits(data_t)),
        .W (FIFO_ADDR_BITS)
    )
    fifo_rx_unit
    (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_rd     (i_rd_uart),
        .i_wr     (rx_done_tick),                   // Dropped when full
        .i_w_data (rx_dout),
        .o_empty  (o_rx_empty),
        .o_full   (),
        .o_r_data (o_r_data)
    );

    // Transmit path, host to FIFO to line
    fifo
    #(
        .B ($bits(data_t)),
        .W (FIFO_ADDR_BITS)
    )
    fifo_tx_unit
    (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_rd     (tx_done_tick),                   // Byte leaves after its frame
        .i_wr     (i_wr_uart),
        .i_w_data (i_w_data),
        .o_empty  (tx_fifo_empty),
        .o_full   (o_tx_full),
        .o_r_data (tx_fifo_out)
    );

    assign tx_start = ~tx_fifo_empty;               // Send while anything queued

    uart_tx uart_tx_unit
    (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_tx_start     (tx_start),
        .i_s_tick       (s_tick),
        .i_din          (tx_fifo_out),
        .o_tx_done_tick (tx_done_tick),
        .o_tx           (o_tx)
    );

endmodule

//--- hdl/uart_tx.sv
`timescale 1ns/1ns

module uart_tx
    (
        input  logic            i_clk,
        input  logic            i_reset,
        input  logic            i_tx_start,         // Byte waiting at i_din
        input  logic            i_s_tick,           // 16x oversampling tick
        input  uart_pkg::data_t i_din,
        output logic            o_tx_done_tick,     // End of stop bit
        output logic            o_tx                // Serial line
    );

    import uart_pkg::*;

    uart_state_t          state_reg, state_next;
    logic [TICK_BITS-1:0] s_reg, s_next;            // Ticks within a bit
    logic [CNT_BITS-1:0]  n_reg, n_next;            // Data bits sent
    data_t                b_reg, b_next;            // Outgoing byte, shifts right
    logic                 tx_reg, tx_next;          // Registered line level

    // Control, line held high out of reset
    always_ff @(posedge i_clk, posedge i_reset)
    begin
        if (i_reset)
        begin
            state_reg <= ST_IDLE;
            s_reg     <= '0;
            n_reg     <= '0;
            tx_reg    <= 1'b1;
        end
        else
        begin
            state_reg <= state_next;
            s_reg     <= s_next;
            n_reg     <= n_next;
            tx_reg    <= tx_next;
        end
    end

    always_ff @(posedge i_clk)
    begin
        b_reg <= b_next;
    end

    always_comb
    begin
        state_next     = state_reg;
        s_next         = s_reg;
        n_next         = n_reg;
        b_next         = b_reg;
        tx_next        = tx_reg;
        o_tx_done_tick = 1'b0;

        case (state_reg)
            ST_IDLE:
            begin
                tx_next = 1'b1;                     // Idle line
                if (i_tx_start)
                begin
                    state_next = ST_START;
                    s_next     = '0;
                    b_next     = i_din;             // Latch byte
                end
            end
            ST_START:
            begin
                tx_next = 1'b0;                     // Start bit
                if (i_s_tick)
                begin
                    if (s_reg == TICK_BITS'(SB_TICKS - 1))
                    begin
                        state_next = ST_DATA;
                        s_next     = '0;
                        n_next     = '0;
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            ST_DATA:
            begin
                tx_next = b_reg[0];                 // LSB first
                if (i_s_tick)
                begin
                    if (s_reg == TICK_BITS'(SB_TICKS - 1))
                    begin
                        s_next = '0;
                        b_next = b_reg >> 1;
                        if (n_reg == CNT_BITS'(DATA_BITS - 1))
                            state_next = ST_STOP;
                        else
                            n_next = n_reg + 1'b1;
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            ST_STOP:
            begin
                tx_next = 1'b1;                     // Stop bit
                if (i_s_tick)
                begin
                    if (s_reg == TICK_BITS'(SB_TICKS - 1))
                    begin
                        state_next     = ST_IDLE;
                        o_tx_done_tick = 1'b1;      // Pops the transmit FIFO
                    end
                    else
                        s_next = s_reg + 1'b1;
                end
            end
            default:
                state_next = ST_IDLE;
        endcase
    end

    assign o_tx = tx_reg;

endmodule

//--- run_uart_sim.sh
#!/usr/bin/env bash
# Build the UART testbench with Verilator, run it, look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module uart_tb -o uart_sim

# Simulator status is ignored here, the printed result decides
output=$(./obj_dir/uart_sim 2>&1 || true)
echo "$output"

if grep -qx "PASS: all tests" <<< "$output"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- sim/uart_tb.sv
`timescale 1ns/1ns

module uart_tb;

    import uart_pkg::*;

    typedef enum logic [1:0]
    {
        MODE_LOOP,                                  // Loopback write then drain
        MODE_BURST,                                 // Back-to-back writes past full
        MODE_OVERFLOW,                              // Injected frames, nothing read
        MODE_GLITCH                                 // Short low pulse then one frame
    } mode_t;

    typedef struct packed
    {
        mode_t                 mode;
        logic [DVSR_BITS-1:0]  dvsr;
        logic [7:0]            count;               // Bytes or frames in the row
        logic [31:0]           fixed;               // First four bytes, byte 0 in bits 7:0
    } row_t;

    // Remaining bytes of a row come from $urandom
    row_t stim_table [5] = '{
        '{MODE_LOOP,     11'd4,  8'd8,  32'h00FF_A55A},
        '{MODE_LOOP,     11'd13, 8'd16, 32'h807E_0181},
        '{MODE_BURST,    11'd20, 8'd20, 32'h55AA_0FF0},
        '{MODE_OVERFLOW, 11'd4,  8'd18, 32'hC33C_9669},
        '{MODE_GLITCH,   11'd7,  8'd1,  32'h0000_00D2}
    };

    logic                 clk;
    logic                 reset;
    logic [DVSR_BITS-1:0] dvsr;
    logic                 wr_uart;
    data_t                w_data;
    logic                 tx_full;
    logic                 rd_uart;
    data_t                r_data;
    logic                 rx_empty;
    logic                 tx_line;
    logic                 inj_line;                 // Hand-built frames
    logic                 loop_en;
    wire                  rx_line;

    data_t exp_q [$];                               // Bytes due at o_r_data
    data_t mon_q [$];                               // Bytes due on o_tx

    assign rx_line = loop_en ? tx_line : inj_line;  // Loopback unless overridden

    uart_top dut0
    (
        .i_clk      (clk),
        .i_reset    (reset),
        .i_dvsr     (dvsr),
        .i_rx       (rx_line),
        .o_tx       (tx_line),
        .i_wr_uart  (wr_uart),
        .i_w_data   (w_data),
        .o_tx_full  (tx_full),
        .i_rd_uart  (rd_uart),
        .o_r_data   (r_data),
        .o_rx_empty (rx_empty)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // 40 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input data_t got, input data_t expected);
        if (got !== expected)
            abort_run($sformatf("FAIL %s: got 0x%02h expected 0x%02h", name, got, expected));
    endtask

    task automatic check_flag(input string name, input logic got, input logic expected);
        if (got !== expected)
            abort_run($sformatf("FAIL %s: got 0x%0h expected 0x%0h", name, got, expected));
    endtask

    // Drive point, 5 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    function automatic data_t pick_byte(input logic [31:0] fixed, input int k);
        if (k < 4)
            return data_t'(fixed >> (8 * k));
        else
            return data_t'($urandom);
    endfunction

    // New rate settles after the old period wraps
    task automatic set_divisor(input logic [DVSR_BITS-1:0] new_dvsr);
        int old_dvsr;
        old_dvsr = int'(dvsr);
        next_cycle();
        dvsr = new_dvsr;
        repeat (old_dvsr + int'(new_dvsr) + 4) next_cycle();
    endtask

    // One write per cycle into an empty transmit FIFO
    task automatic write_bytes(input row_t row);
        int    k;
        int    taken;                               // Writes the FIFO accepted
        data_t b;
        taken = 0;
        for (k = 0; k < int'(row.count); k++)
        begin
            b = pick_byte(row.fixed, k);
            next_cycle();
            // No frame ends within a burst
            check_flag("o_tx_full", tx_full, taken >= (1 << FIFO_ADDR_BITS));
            if (taken < (1 << FIFO_ADDR_BITS))
            begin
                exp_q.push_back(b);
                mon_q.push_back(b);
                taken++;
            end
            wr_uart = 1'b1;                         // Dropped by the FIFO when full
            w_data  = b;
        end
        next_cycle();
        wr_uart = 1'b0;
        check_flag("o_tx_full", tx_full, taken >= (1 << FIFO_ADDR_BITS));
    endtask

    task automatic send_frame(input data_t b);
        logic [DATA_BITS+1:0] bits;
        int                   k;
        int                   p;
        bits = {1'b1, b, 1'b0};                     // Stop, data, start
        p    = int'(dvsr) + 1;
        next_cycle();
        for (k = 0; k < DATA_BITS + 2; k++)
        begin
            inj_line = bits[0];
            bits     = bits >> 1;
            repeat (SB_TICKS * p) next_cycle();
        end
    endtask

    // Read every expected byte, then the FIFO must be empty
    task automatic drain_and_confirm();
        data_t want;
        while (exp_q.size() != 0)
        begin
            next_cycle();
            while (rx_empty)
                next_cycle();
            want = exp_q.pop_front();
            check_byte("o_r_data", r_data, want);
            rd_uart = 1'b1;
            next_cycle();
            rd_uart = 1'b0;
        end
        next_cycle();
        check_flag("o_rx_empty", rx_empty, 1'b1);
        while (mon_q.size() != 0)                   // Last stop bit still on the line
            next_cycle();
    endtask

    task automatic run_overflow(input row_t row);
        int    k;
        data_t b;
        loop_en = 1'b0;
        for (k = 0; k < int'(row.count); k++)
        begin
            b = pick_byte(row.fixed, k);
            if (k < (1 << FIFO_ADDR_BITS))         // Later frames find it full
                exp_q.push_back(b);
            send_frame(b);
        end
        repeat (SB_TICKS * (int'(dvsr) + 1)) next_cycle();
        check_flag("o_rx_empty", rx_empty, 1'b0);
        drain_and_confirm();
    endtask

    task automatic run_glitch(input row_t row);
        int    p;
        data_t b;
        p       = int'(dvsr) + 1;
        loop_en = 1'b0;
        next_cycle();
        inj_line = 1'b0;
        repeat (4 * p) next_cycle();                // Quarter bit low
        inj_line = 1'b1;
        // Longer than any frame a false start could build
        repeat ((DATA_BITS + 2) * SB_TICKS * p) next_cycle();
        check_flag("o_rx_empty", rx_empty, 1'b1);
        b = pick_byte(row.fixed, 0);
        exp_q.push_back(b);
        send_frame(b);
        drain_and_confirm();
    endtask

    // Checks every frame the DUT sends, sampled at bit centres
    initial
    begin : line_monitor
        int    p;
        int    k;
        data_t bits_left;
        @(negedge reset);
        forever
        begin
            @(negedge tx_line);
            p = int'(dvsr) + 1;
            if (mon_q.size() == 0)
                abort_run("a frame appeared on o_tx with no byte waiting to be sent");
            bits_left = mon_q[0];
            repeat (SB_TICKS / 2 * p) @(negedge clk);
            check_flag("o_tx start bit", tx_line, 1'b0);
            for (k = 0; k < DATA_BITS; k++)
            begin
                repeat (SB_TICKS * p) @(negedge clk);
                check_flag($sformatf("o_tx data bit %0d", k), tx_line, bits_left[0]);
                bits_left = bits_left >> 1;         // LSB first
            end
            repeat (SB_TICKS * p) @(negedge clk);
            check_flag("o_tx stop bit", tx_line, 1'b1);
            mon_q.delete(0);
        end
    end

    // Budget from all frames at the slowest rate, doubled
    initial
    begin : watchdog
        longint frames;
        longint max_p;
        longint limit_ns;
        int     r;
        frames = 0;
        max_p  = 1;
        for (r = 0; r < $size(stim_table); r++)
        begin
            frames += longint'(stim_table[r].count);
            if (longint'(stim_table[r].dvsr) + 1 > max_p)
                max_p = longint'(stim_table[r].dvsr) + 1;
        end
        limit_ns = 2 * frames * (DATA_BITS + 2) * SB_TICKS * max_p * 40;
        #(limit_ns);
        abort_run("timeout: receive FIFO never delivered expected bytes");
    end

    initial
    begin : main_sequence
        int   r;
        void'($urandom(85053));
        reset    = 1'b1;
        dvsr     = '0;
        wr_uart  = 1'b0;
        w_data   = '0;
        rd_uart  = 1'b0;
        inj_line = 1'b1;                            // Idle line
        loop_en  = 1'b1;
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;
        next_cycle();
        check_flag("o_tx", tx_line, 1'b1);
        check_flag("o_rx_empty", rx_empty, 1'b1);
        check_flag("o_tx_full", tx_full, 1'b0);

        for (r = 0; r < $size(stim_table); r++)
        begin
            set_divisor(stim_table[r].dvsr);
            case (stim_table[r].mode)
                MODE_LOOP, MODE_BURST:
                begin
                    loop_en = 1'b1;
                    write_bytes(stim_table[r]);
                    drain_and_confirm();
                end
                MODE_OVERFLOW:
                    run_overflow(stim_table[r]);
                MODE_GLITCH:
                    run_glitch(stim_table[r]);
            endcase
            repeat (18 * (int'(dvsr) + 1)) next_cycle();   // Line back to idle
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- src.f
hdl/uart_pkg.sv
hdl/fifo.sv
hdl/baud_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_top.sv
sim/uart_tb.sv
